// File: common/vfu_pkg.sv
package vfu_pkg;

  // Lane geometry
  localparam int unsigned ELEN  = 32;
  localparam int unsigned ELENB = ELEN / 8;

  // Element width code, also the right shift from bytes per lane
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vew_e;

  typedef enum logic [3:0] {
    VADD  = 4'd0,
    VSUB  = 4'd1,
    VAND  = 4'd2,
    VOR   = 4'd3,
    VXOR  = 4'd4,
    VSLL  = 4'd5,
    VSRL  = 4'd6,
    VMIN  = 4'd7,
    VMAX  = 4'd8,
    VMINU = 4'd9
  } vfu_op_e;

  typedef logic [2:0]      vfu_id_t;
  typedef logic [4:0]      vreg_idx_t;
  typedef logic [4:0]      gpr_idx_t;
  typedef logic [8:0]      vlen_t;
  typedef logic [ELEN-1:0] elen_t;

  // Full register file word address
  typedef logic [7:0] vreg_addr_t;

  typedef struct packed {
    vfu_id_t   id;
    vfu_op_e   op;
    vew_e      sew;
    vlen_t     vl;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    vreg_idx_t vd;
    gpr_idx_t  rd;
    elen_t     rs1;
    logic      use_vs1;
    logic      is_scalar;
  } vfu_req_t;

  typedef struct packed {
    vfu_id_t  id;
    gpr_idx_t rd;
    logic     wb;
    elen_t    result;
  } vfu_rsp_t;

  // Travels with every issued word down to the writeback
  typedef struct packed {
    vfu_id_t    id;
    vreg_addr_t vd_addr;
    logic       wb;
    logic       last;
    gpr_idx_t   rd;
  } vfu_tag_t;

endpackage

// File: decode/vfu_decode.sv
`timescale 1ns/100ps

module vfu_decode import vfu_pkg::*; #(
  parameter int unsigned NrLanes          = 4,
  parameter int unsigned NrWordsPerVector = 8
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  vfu_req_t                           req_i,
  input  logic                               req_valid_i,
  output logic                               req_ready_o,
  output vreg_addr_t [1:0]                   vrf_raddr_o,
  output logic       [1:0]                   vrf_re_o,
  input  logic       [1:0][NrLanes*ELEN-1:0] vrf_rdata_i,
  input  logic       [1:0]                   vrf_rvalid_i,
  output logic       [NrLanes*ELEN-1:0]      op1_o,
  output logic       [NrLanes*ELEN-1:0]      op2_o,
  output vfu_op_e                            op_o,
  output vew_e                               sew_o,
  output vfu_tag_t                           tag_o,
  output logic                               issue_valid_o,
  input  logic                               issue_ready_i
);

  localparam int unsigned WordIdxW = $clog2(NrWordsPerVector);
  localparam int unsigned MaxElems = NrLanes * ELENB;
  localparam int unsigned EpwW     = $clog2(MaxElems) + 1;
  localparam int unsigned CntW     = $bits(vlen_t) + 1;

  vlen_t           cnt_q;
  logic [CntW-1:0] cnt_next;
  logic [EpwW-1:0] elem_per_word;
  logic            first_word;
  logic            last_word;
  logic            operands_ready;
  logic            issued;
  vreg_addr_t      vs2_addr_q;
  vreg_addr_t      vs1_addr_q;
  vreg_addr_t      vd_addr_q;
  vreg_addr_t      vs2_addr;
  vreg_addr_t      vs1_addr;
  vreg_addr_t      vd_addr;

  ////////////////////
  // Element counter
  ////////////////////

  assign elem_per_word = EpwW'(MaxElems) >> req_i.sew;
  assign cnt_next      = CntW'(cnt_q) + CntW'(elem_per_word);
  assign first_word    = (cnt_q == '0);
  assign last_word     = req_i.is_scalar || (cnt_next >= CntW'(req_i.vl));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (issued) begin
      cnt_q <= last_word ? '0 : vlen_t'(cnt_next);
    end
  end

  ////////////////////
  // Read addresses
  ////////////////////

  // First word goes straight from the register numbers
  assign vs2_addr = first_word ? vreg_addr_t'(req_i.vs2) << WordIdxW : vs2_addr_q;
  assign vs1_addr = first_word ? vreg_addr_t'(req_i.vs1) << WordIdxW : vs1_addr_q;
  assign vd_addr  = first_word ? vreg_addr_t'(req_i.vd) << WordIdxW : vd_addr_q;

  always_ff @(posedge clk_i) begin
    if (issued) begin
      vs2_addr_q <= vs2_addr + 1'b1;
      vs1_addr_q <= vs1_addr + 1'b1;
      vd_addr_q  <= vd_addr + 1'b1;
    end
  end

  // Port 0 reads vs2, port 1 reads vs1
  assign vrf_raddr_o[0] = vs2_addr;
  assign vrf_raddr_o[1] = vs1_addr;
  assign vrf_re_o[0]    = req_valid_i;
  assign vrf_re_o[1]    = req_valid_i && req_i.use_vs1;

  assign operands_ready = (!vrf_re_o[0] || vrf_rvalid_i[0]) &&
                          (!vrf_re_o[1] || vrf_rvalid_i[1]);

  ////////////////////
  // Issue
  ////////////////////

  assign issue_valid_o = req_valid_i && operands_ready;
  assign issued        = issue_valid_o && issue_ready_i;

  // Pop the queue with the last word
  assign req_ready_o = issued && last_word;

  always_comb begin
    if (req_i.use_vs1) begin
      op1_o = vrf_rdata_i[1];
    end else begin
      // Scalar operand copied into every element
      unique case (req_i.sew)
        EW_8:    op1_o = {MaxElems{req_i.rs1[7:0]}};
        EW_16:   op1_o = {(NrLanes * 2){req_i.rs1[15:0]}};
        default: op1_o = {NrLanes{req_i.rs1}};
      endcase
    end
  end

  assign op2_o = vrf_rdata_i[0];
  assign op_o  = req_i.op;
  assign sew_o = req_i.sew;

  assign tag_o = '{
    id:      req_i.id,
    vd_addr: vd_addr,
    wb:      req_i.is_scalar,
    last:    last_word,
    rd:      req_i.rd
  };

  a_cnt_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    req_valid_i |-> CntW'(cnt_q) <= CntW'(req_i.vl) + CntW'(elem_per_word))
    else $error("element counter ran past vl");

endmodule

// File: design/vfu_result.sv
`timescale 1ns/100ps

module vfu_result import vfu_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic [NrLanes*ELEN-1:0]  result_i,
  input  vfu_tag_t                 tag_i,
  input  logic                     valid_i,
  output logic                     ready_o,
  output vreg_addr_t               vrf_waddr_o,
  output logic [NrLanes*ELEN-1:0]  vrf_wdata_o,
  output logic                     vrf_we_o,
  output logic [NrLanes*ELENB-1:0] vrf_wbe_o,
  input  logic                     vrf_wvalid_i,
  output vfu_rsp_t                 rsp_o,
  output logic                     rsp_valid_o,
  input  logic                     rsp_ready_i
);

  logic accept;

  // Vector words go to the register file
  assign vrf_we_o    = valid_i && !tag_i.wb && !rsp_valid_o;
  assign vrf_waddr_o = tag_i.vd_addr;
  assign vrf_wdata_o = result_i;
  assign vrf_wbe_o   = '1;

  // Scalar words need only a free response slot
  assign ready_o = !rsp_valid_o && (tag_i.wb || vrf_wvalid_i);
  assign accept  = valid_i && ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_o <= 1'b0;
    end else if (accept && (tag_i.wb || tag_i.last)) begin
      rsp_valid_o <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && (tag_i.wb || tag_i.last)) begin
      rsp_o.id     <= tag_i.id;
      rsp_o.rd     <= tag_i.rd;
      rsp_o.wb     <= tag_i.wb;
      rsp_o.result <= tag_i.wb ? result_i[ELEN-1:0] : '0;
    end
  end

  // Write request holds its word until the register file takes it
  a_write_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    vrf_we_o && !vrf_wvalid_i |=> vrf_we_o && !tag_i.wb && $stable(vrf_waddr_o))
    else $error("register file write dropped or redirected before completion");

endmodule

// File: design/vfu_spill_reg.sv
`timescale 1ns/100ps

module vfu_spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_i,
  input  T     data_i,
  input  logic valid_i,
  output logic ready_o,
  output T     data_o,
  output logic valid_o,
  input  logic ready_i
);

  // Slot a takes new items, slot b keeps the older one when stalled
  T     a_data_q;
  T     b_data_q;
  logic a_full_q;
  logic b_full_q;
  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill || (a_full_q && !a_drain);
      b_full_q <= b_fill || (b_full_q && !b_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Older item first
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  assign valid_o = a_full_q || b_full_q;
  assign ready_o = !a_full_q || !b_full_q;

  a_out_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("spill register output changed while stalled");

endmodule

// File: design/vfu_top.sv
`timescale 1ns/100ps

module vfu_top import vfu_pkg::*; #(
  parameter int unsigned NrLanes          = 4,
  parameter int unsigned NrWordsPerVector = 8
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  vfu_req_t                           req_i,
  input  logic                               req_valid_i,
  output logic                               req_ready_o,
  output vfu_rsp_t                           rsp_o,
  output logic                               rsp_valid_o,
  input  logic                               rsp_ready_i,
  output vreg_addr_t                         vrf_waddr_o,
  output logic       [NrLanes*ELEN-1:0]      vrf_wdata_o,
  output logic                               vrf_we_o,
  output logic       [NrLanes*ELENB-1:0]     vrf_wbe_o,
  input  logic                               vrf_wvalid_i,
  output vreg_addr_t [1:0]                   vrf_raddr_o,
  output logic       [1:0]                   vrf_re_o,
  input  logic       [1:0][NrLanes*ELEN-1:0] vrf_rdata_i,
  input  logic       [1:0]                   vrf_rvalid_i
);

  typedef struct packed {
    logic [NrLanes*ELEN-1:0] word;
    vfu_tag_t                tag;
  } lane_result_t;

  vfu_req_t                q_req;
  logic                    q_valid;
  logic                    q_ready;
  logic [NrLanes*ELEN-1:0] issue_op1;
  logic [NrLanes*ELEN-1:0] issue_op2;
  vfu_op_e                 issue_op;
  vew_e                    issue_sew;
  vfu_tag_t                issue_tag;
  logic                    issue_valid;
  logic                    issue_ready;
  lane_result_t            lane_res;
  logic                    lane_valid;
  logic                    lane_ready;
  lane_result_t            buf_res;
  logic                    buf_valid;
  logic                    buf_ready;

  ////////////////////
  // Operation queue
  ////////////////////

  vfu_spill_reg #(
    .T(vfu_req_t)
  ) i_op_queue (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .data_i (req_i),
    .valid_i(req_valid_i),
    .ready_o(req_ready_o),
    .data_o (q_req),
    .valid_o(q_valid),
    .ready_i(q_ready)
  );

  vfu_decode #(
    .NrLanes         (NrLanes),
    .NrWordsPerVector(NrWordsPerVector)
  ) i_decode (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (q_req),
    .req_valid_i  (q_valid),
    .req_ready_o  (q_ready),
    .vrf_raddr_o  (vrf_raddr_o),
    .vrf_re_o     (vrf_re_o),
    .vrf_rdata_i  (vrf_rdata_i),
    .vrf_rvalid_i (vrf_rvalid_i),
    .op1_o        (issue_op1),
    .op2_o        (issue_op2),
    .op_o         (issue_op),
    .sew_o        (issue_sew),
    .tag_o        (issue_tag),
    .issue_valid_o(issue_valid),
    .issue_ready_i(issue_ready)
  );

  ////////////////////
  // Execute and writeback
  ////////////////////

  vfu_alu_lanes #(
    .NrLanes(NrLanes)
  ) i_lanes (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .op1_i   (issue_op1),
    .op2_i   (issue_op2),
    .op_i    (issue_op),
    .sew_i   (issue_sew),
    .tag_i   (issue_tag),
    .valid_i (issue_valid),
    .ready_o (issue_ready),
    .result_o(lane_res.word),
    .tag_o   (lane_res.tag),
    .valid_o (lane_valid),
    .ready_i (lane_ready)
  );

  vfu_spill_reg #(
    .T(lane_result_t)
  ) i_result_buf (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .data_i (lane_res),
    .valid_i(lane_valid),
    .ready_o(lane_ready),
    .data_o (buf_res),
    .valid_o(buf_valid),
    .ready_i(buf_ready)
  );

  vfu_result #(
    .NrLanes(NrLanes)
  ) i_result (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .result_i    (buf_res.word),
    .tag_i       (buf_res.tag),
    .valid_i     (buf_valid),
    .ready_o     (buf_ready),
    .vrf_waddr_o (vrf_waddr_o),
    .vrf_wdata_o (vrf_wdata_o),
    .vrf_we_o    (vrf_we_o),
    .vrf_wbe_o   (vrf_wbe_o),
    .vrf_wvalid_i(vrf_wvalid_i),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i)
  );

endmodule

// File: execute/vfu_alu_lanes.sv
`timescale 1ns/100ps

module vfu_alu_lanes import vfu_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [NrLanes*ELEN-1:0] op1_i,
  input  logic [NrLanes*ELEN-1:0] op2_i,
  input  vfu_op_e                 op_i,
  input  vew_e                    sew_i,
  input  vfu_tag_t                tag_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  output logic [NrLanes*ELEN-1:0] result_o,
  output vfu_tag_t                tag_o,
  output logic                    valid_o,
  input  logic                    ready_i
);

  localparam int unsigned WordW = NrLanes * ELEN;

  // One element of width w in the low bits, a is operand 1
  function automatic elen_t elem_op(vfu_op_e op, elen_t a, elen_t b, int unsigned w);
    elen_t                  mask;
    elen_t                  ua;
    elen_t                  ub;
    logic signed [ELEN-1:0] sa;
    logic signed [ELEN-1:0] sb;
    logic [4:0]             shamt;
    elen_t                  res;
    mask  = (w == ELEN) ? '1 : (elen_t'(1) << w) - 1'b1;
    ua    = a & mask;
    ub    = b & mask;
    sa    = $signed(ua << (ELEN - w)) >>> (ELEN - w);
    sb    = $signed(ub << (ELEN - w)) >>> (ELEN - w);
    shamt = a[4:0] & 5'(w - 1);
    unique case (op)
      VADD:    res = b + a;
      VSUB:    res = b - a;
      VAND:    res = b & a;
      VOR:     res = b | a;
      VXOR:    res = b ^ a;
      VSLL:    res = ub << shamt;
      VSRL:    res = ub >> shamt;
      VMIN:    res = (sb < sa) ? ub : ua;
      VMAX:    res = (sb > sa) ? ub : ua;
      VMINU:   res = (ub < ua) ? ub : ua;
      default: res = '0;
    endcase
    return res & mask;
  endfunction

  logic [WordW-1:0] result_d;

  ////////////////////
  // Lane datapath
  ////////////////////

  always_comb begin
    elen_t tmp;
    result_d = '0;
    unique case (sew_i)
      EW_8: begin
        for (int i = 0; i < NrLanes * ELENB; i++) begin
          tmp = elem_op(op_i, elen_t'(op1_i[8*i +: 8]), elen_t'(op2_i[8*i +: 8]), 8);
          result_d[8*i +: 8] = tmp[7:0];
        end
      end
      EW_16: begin
        for (int i = 0; i < NrLanes * 2; i++) begin
          tmp = elem_op(op_i, elen_t'(op1_i[16*i +: 16]), elen_t'(op2_i[16*i +: 16]), 16);
          result_d[16*i +: 16] = tmp[15:0];
        end
      end
      default: begin
        for (int i = 0; i < NrLanes; i++) begin
          result_d[ELEN*i +: ELEN] = elem_op(op_i, op1_i[ELEN*i +: ELEN],
                                             op2_i[ELEN*i +: ELEN], ELEN);
        end
      end
    endcase
    // Scalar result is element 0, sign-extended
    if (tag_i.wb) begin
      unique case (sew_i)
        EW_8:    result_d[ELEN-1:0] = {{24{result_d[7]}}, result_d[7:0]};
        EW_16:   result_d[ELEN-1:0] = {{16{result_d[15]}}, result_d[15:0]};
        default: result_d[ELEN-1:0] = result_d[ELEN-1:0];
      endcase
    end
  end

  ////////////////////
  // Output stage
  ////////////////////

  assign ready_o = !valid_o || ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else if (ready_o) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      result_o <= result_d;
      tag_o    <= tag_i;
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the vfu testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module vfu_tb \
  -f sources.f -o vfu_sim || { echo "Build failed"; exit 1; }
./obj_dir/vfu_sim > sim.log 2>&1
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && { echo "Simulation failed"; exit 1; }
grep -q '\*\* PASS \*\*' sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"

// File: sources.f
+incdir+verif
common/vfu_pkg.sv
design/vfu_spill_reg.sv
decode/vfu_decode.sv
execute/vfu_alu_lanes.sv
design/vfu_result.sv
design/vfu_top.sv
verif/vfu_tb.sv

// File: verif/vfu_tests.svh
`ifndef VFU_TESTS_SVH
`define VFU_TESTS_SVH

//////////////////////
// Reference model
//////////////////////

// One element, operands already cut to w bits, a is operand 1
function automatic logic [31:0] ref_elem(vfu_op_e op, logic [31:0] a, logic [31:0] b,
                                         int unsigned w);
  logic [31:0] mask;
  longint      sa;
  longint      sb;
  int unsigned sh;
  logic [31:0] res;
  mask = (w == 32) ? 32'hffff_ffff : (32'd1 << w) - 32'd1;
  sa   = a[w-1] ? longint'(a) - (longint'(1) << w) : longint'(a);
  sb   = b[w-1] ? longint'(b) - (longint'(1) << w) : longint'(b);
  sh   = a % w;
  case (op)
    VADD:    res = a + b;
    VSUB:    res = b - a;
    VAND:    res = a & b;
    VOR:     res = a | b;
    VXOR:    res = a ^ b;
    VSLL:    res = b << sh;
    VSRL:    res = b >> sh;
    VMIN:    res = (sa < sb) ? a : b;
    VMAX:    res = (sa > sb) ? a : b;
    VMINU:   res = (a < b) ? a : b;
    default: res = '0;
  endcase
  return res & mask;
endfunction

function automatic word_t ref_word(vfu_req_t r, word_t src1, word_t src2);
  int unsigned w;
  logic [31:0] mask;
  logic [31:0] a;
  logic [31:0] b;
  word_t       res;
  w    = 8 << r.sew;
  mask = (w == 32) ? 32'hffff_ffff : (32'd1 << w) - 32'd1;
  res  = '0;
  for (int i = 0; i < WordW / w; i++) begin
    // Without vs1 every element sees the same rs1 value
    a   = r.use_vs1 ? 32'(src1 >> (i * w)) & mask : r.rs1 & mask;
    b   = 32'(src2 >> (i * w)) & mask;
    res = res | (word_t'(ref_elem(r.op, a, b, w)) << (i * w));
  end
  return res;
endfunction

function automatic int unsigned words_of(vfu_req_t r);
  int unsigned epw;
  epw = (NrLanes * ELENB) >> r.sew;
  if (r.is_scalar) begin
    return 1;
  end
  return (32'(r.vl) + epw - 1) / epw;
endfunction

function automatic int unsigned word_addr(vreg_idx_t v, int unsigned k);
  return 32'(v) * NrWords + k;
endfunction

function automatic vfu_req_t make_req(vfu_id_t id, vfu_op_e op, vew_e sew, vlen_t vl,
                                      vreg_idx_t vs1, vreg_idx_t vs2, vreg_idx_t vd,
                                      elen_t rs1, logic use_vs1);
  vfu_req_t r;
  r         = '0;
  r.id      = id;
  r.op      = op;
  r.sew     = sew;
  r.vl      = vl;
  r.vs1     = vs1;
  r.vs2     = vs2;
  r.vd      = vd;
  r.rd      = vd;
  r.rs1     = rs1;
  r.use_vs1 = use_vs1;
  return r;
endfunction

//////////////////////
// Stimulus helpers
//////////////////////

task automatic fill_reg(input int unsigned v);
  for (int k = 0; k < NrWords; k++) begin
    vrf_mem[word_addr(5'(v), k)] = {$random(seed), $random(seed), $random(seed), $random(seed)};
  end
endtask

// Whole expected contents of vd, pushed word by word
task automatic expect_vector(input vfu_req_t r);
  int unsigned n;
  n = words_of(r);
  for (int k = 0; k < NrWords; k++) begin
    if (k < n) begin
      exp_q.push_back(ref_word(r, vrf_mem[word_addr(r.vs1, k)],
                               vrf_mem[word_addr(r.vs2, k)]));
    end else begin
      exp_q.push_back(vrf_mem[word_addr(r.vd, k)]);
    end
  end
endtask

task automatic compare_vector(input string what, input vreg_idx_t vd);
  word_t exp;
  for (int k = 0; k < NrWords; k++) begin
    exp = exp_q.pop_front();
    check($sformatf("%s v%0d word %0d", what, vd, k), exp, vrf_mem[word_addr(vd, k)]);
  end
endtask

task automatic send_req(input vfu_req_t r);
  req       = r;
  req_valid = 1'b1;
  @(negedge clk);
  while (!req_ready) begin
    @(negedge clk);
  end
  @(posedge clk);
  #1;
  req_valid = 1'b0;
endtask

task automatic wait_rsp(input int unsigned n);
  while (rsp_q.size() < n) begin
    @(posedge clk);
    #1;
  end
endtask

task automatic run_vector(input string what, input vfu_req_t r);
  vfu_rsp_t got;
  expect_vector(r);
  send_req(r);
  wait_rsp(1);
  got = rsp_q.pop_front();
  check({what, " rsp id"}, word_t'(r.id), word_t'(got.id));
  check({what, " rsp rd"}, word_t'(r.rd), word_t'(got.rd));
  check({what, " rsp wb"}, '0, word_t'(got.wb));
  compare_vector(what, r.vd);
endtask

//////////////////////
// Directed tests
//////////////////////

task automatic reset_state();
  cur_test = "reset_state";
  check("req_ready_o", word_t'(1'b1), word_t'(req_ready));
  check("rsp_valid_o", '0, word_t'(rsp_valid));
  check("vrf_we_o", '0, word_t'(vrf_we));
  check("vrf_re_o", '0, word_t'(vrf_re));
endtask

task automatic add_sub_full();
  cur_test = "add_sub_full";
  for (int v = 1; v < 5; v++) begin
    fill_reg(v);
  end
  run_vector("vadd", make_req(3'd1, VADD, EW_32, 9'd32, 5'd1, 5'd2, 5'd3, 32'd0, 1'b1));
  run_vector("vsub", make_req(3'd2, VSUB, EW_32, 9'd32, 5'd1, 5'd2, 5'd4, 32'd0, 1'b1));
endtask

task automatic shift_logic_minmax();
  vfu_op_e ops [8] = '{VSLL, VSRL, VAND, VOR, VXOR, VMIN, VMAX, VMINU};
  vew_e    sew;
  vlen_t   vl;
  cur_test = "shift_logic_minmax";
  fill_reg(5);
  fill_reg(6);
  for (int i = 0; i < 8; i++) begin
    for (int j = 0; j < 2; j++) begin
      // Partial last word in both widths
      sew = (j == 0) ? EW_8 : EW_16;
      vl  = (j == 0) ? 9'd37 : 9'd13;
      run_vector($sformatf("%s sew %0d", ops[i].name(), 8 << sew),
                 make_req(3'(i), ops[i], sew, vl, 5'd0, 5'd5, 5'd6, $random(seed), 1'b0));
    end
  end
endtask

task automatic scalar_result();
  vfu_req_t    r;
  vfu_rsp_t    got;
  word_t       exp;
  int unsigned writes_before;
  cur_test = "scalar_result";
  fill_reg(20);
  fill_reg(21);
  for (int i = 0; i < 2; i++) begin
    r = make_req(3'(4 + i), (i == 0) ? VSUB : VMAX, EW_32, 9'd1, 5'd20, 5'd21, 5'd22,
                 $random(seed), i == 0);
    r.is_scalar   = 1'b1;
    r.rd          = 5'd17;
    exp           = ref_word(r, vrf_mem[word_addr(r.vs1, 0)], vrf_mem[word_addr(r.vs2, 0)]);
    writes_before = write_cnt;
    send_req(r);
    wait_rsp(1);
    got = rsp_q.pop_front();
    check("rsp id", word_t'(r.id), word_t'(got.id));
    check("rsp result", word_t'(exp[ELEN-1:0]), word_t'(got.result));
    check("rsp rd", word_t'(5'd17), word_t'(got.rd));
    check("rsp wb", word_t'(1'b1), word_t'(got.wb));
    check("register file writes", word_t'(writes_before), word_t'(write_cnt));
  end
endtask

task automatic back_pressure();
  vfu_req_t reqs [3];
  vfu_rsp_t got;
  cur_test = "back_pressure";
  reqs[0] = make_req(3'd1, VADD, EW_32, 9'd32, 5'd8, 5'd9, 5'd10, 32'd0, 1'b1);
  reqs[1] = make_req(3'd2, VXOR, EW_8, 9'd50, 5'd0, 5'd11, 5'd12, $random(seed), 1'b0);
  reqs[2] = make_req(3'd3, VMINU, EW_16, 9'd64, 5'd13, 5'd14, 5'd15, 32'd0, 1'b1);
  for (int v = 8; v < 16; v++) begin
    fill_reg(v);
  end
  // Sources and destinations are disjoint, so all results are known up front
  for (int i = 0; i < 3; i++) begin
    expect_vector(reqs[i]);
  end
  stall_en = 1'b1;
  for (int i = 0; i < 3; i++) begin
    send_req(reqs[i]);
  end
  wait_rsp(3);
  stall_en = 1'b0;
  for (int i = 0; i < 3; i++) begin
    got = rsp_q.pop_front();
    check("rsp id in order", word_t'(reqs[i].id), word_t'(got.id));
    check("rsp wb", '0, word_t'(got.wb));
    compare_vector($sformatf("instr %0d", i), reqs[i].vd);
  end
endtask

`endif

// File: verif/vfu_tb.sv
`timescale 1ns/100ps

module vfu_tb import vfu_pkg::*; ();

  localparam int unsigned NrLanes       = 4;
  localparam int unsigned NrWords       = 8;
  localparam int unsigned NrVregs       = 32;
  localparam int unsigned WordW         = NrLanes * ELEN;
  localparam int unsigned NumTests      = 5;
  localparam int unsigned CyclesPerTest = 200;

  typedef logic [WordW-1:0] word_t;

  logic                      clk;
  logic                      rst;
  vfu_req_t                  req;
  logic                      req_valid;
  logic                      req_ready;
  vfu_rsp_t                  rsp;
  logic                      rsp_valid;
  logic                      rsp_ready;
  vreg_addr_t                vrf_waddr;
  word_t                     vrf_wdata;
  logic                      vrf_we;
  logic [NrLanes*ELENB-1:0]  vrf_wbe;
  logic                      vrf_wvalid;
  vreg_addr_t [1:0]          vrf_raddr;
  logic [1:0]                vrf_re;
  logic [1:0][WordW-1:0]     vrf_rdata;
  logic [1:0]                vrf_rvalid;

  word_t       vrf_mem [NrVregs * NrWords];
  vfu_rsp_t    rsp_q [$];
  word_t       exp_q [$];
  int unsigned write_cnt = 0;
  integer      seed = 32'h3298_0009;
  logic        stall_en = 1'b0;
  string       cur_test = "reset";

  vfu_top #(
    .NrLanes         (NrLanes),
    .NrWordsPerVector(NrWords)
  ) i_vfu_top (
    .clk_i       (clk),
    .rst_i       (rst),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .rsp_o       (rsp),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .vrf_waddr_o (vrf_waddr),
    .vrf_wdata_o (vrf_wdata),
    .vrf_we_o    (vrf_we),
    .vrf_wbe_o   (vrf_wbe),
    .vrf_wvalid_i(vrf_wvalid),
    .vrf_raddr_o (vrf_raddr),
    .vrf_re_o    (vrf_re),
    .vrf_rdata_i (vrf_rdata),
    .vrf_rvalid_i(vrf_rvalid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////
  // Register file model
  ////////////////////

  // Reads answered in the same cycle
  // Inverted data while rvalid is low
  assign vrf_rdata[0] = vrf_rvalid[0] ? vrf_mem[vrf_raddr[0]] : ~vrf_mem[vrf_raddr[0]];
  assign vrf_rdata[1] = vrf_rvalid[1] ? vrf_mem[vrf_raddr[1]] : ~vrf_mem[vrf_raddr[1]];

  // Handshakes sampled mid-cycle, where all inputs are settled
  always @(negedge clk) begin
    if (!rst && vrf_we && vrf_wvalid) begin
      // Only enabled bytes are written
      for (int b = 0; b < NrLanes * ELENB; b++) begin
        if (vrf_wbe[b]) begin
          vrf_mem[vrf_waddr][8*b +: 8] = vrf_wdata[8*b +: 8];
        end
      end
      write_cnt++;
    end
    if (!rst && rsp_valid && rsp_ready) begin
      rsp_q.push_back(rsp);
    end
  end

  // Stall pattern for rvalid, wvalid and rsp_ready
  initial begin
    logic        stall;
    logic [31:0] rnd;
    vrf_rvalid = 2'b11;
    vrf_wvalid = 1'b1;
    rsp_ready  = 1'b1;
    forever begin
      @(posedge clk);
      stall = stall_en;
      rnd   = $random(seed);
      #1;
      if (stall) begin
        vrf_rvalid = rnd[1:0];
        vrf_wvalid = rnd[2];
        rsp_ready  = rnd[3];
      end else begin
        vrf_rvalid = 2'b11;
        vrf_wvalid = 1'b1;
        rsp_ready  = 1'b1;
      end
    end
  end

  task automatic check(input string what, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("ERROR %s (%s): expected %h, actual %h", cur_test, what, exp, act);
      $display("** FAIL **");
      $fatal(1, "mismatch in test %s", cur_test);
    end
  endtask

  `include "vfu_tests.svh"

  initial begin
    repeat (CyclesPerTest * NumTests) @(posedge clk);
    $display("Timeout: test %s stopped responding", cur_test);
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst       = 1'b1;
    req       = '0;
    req_valid = 1'b0;
    for (int a = 0; a < NrVregs * NrWords; a++) begin
      vrf_mem[a] = {4{32'hc0de_0000 | 32'(a)}};
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    reset_state();
    add_sub_full();
    shift_logic_minmax();
    scalar_result();
    back_pressure();
    $display("** PASS **");
    $finish;
  end

endmodule
